// File: sp3_rx_defs.svh
/* widths, header codes, lock and unlock thresholds and the settle count
   for the SPROCKET3 uplink receive front end */

`ifndef SP3_RX_DEFS_SVH
`define SP3_RX_DEFS_SVH

//////////////////////
// widths
//////////////////////

// lane word and transceiver word width
`define SP3_WORD_W 32

// slip offset width, offsets 0 to 31
`define SP3_SLIP_W 5

//////////////////////
// framing
//////////////////////

// the two legal header nibbles in bits 31:28 of an aligned word
`define SP3_HDR_A 4'b1010
`define SP3_HDR_B 4'b0101

// good headers in a row before lock
`define SP3_LOCK_COUNT 8

// bad headers in a row before lock is dropped
`define SP3_UNLOCK_COUNT 4

// lane words skipped after a slip, lets the new window fill the history
`define SP3_SETTLE_WORDS 2

`endif

// File: sp3_rx_pkg.sv
/* shared types for the SPROCKET3 receive front end: aligner state enum */

`default_nettype none

package sp3_rx_pkg;

   //////////////////////
   // frame aligner
   //////////////////////

   // search: counting good headers toward lock
   // slip_req: request held until the slipper acks
   // slip_wait: waiting for ack to fall
   // settle: skipping words while the new window fills
   // locked: counting bad headers toward loss of lock
   typedef enum logic [2:0] {
      SEARCH,
      SLIP_REQ,
      SLIP_WAIT,
      SETTLE,
      LOCKED
   } align_state_t;

endpackage

`default_nettype wire

// File: sp3_lane_if.sv
/* per-lane link between bitslip and frame aligner: aligned word,
   its strobe and the four-phase slip handshake */

`timescale 1ns/10ps
`default_nettype none

`include "sp3_rx_defs.svh"

interface sp3_lane_if;

   // aligned lane word, valid for one cycle on aligned_valid
   logic [`SP3_WORD_W-1:0] aligned;
   logic                   aligned_valid;

   // four-phase slip handshake
   // req up, ack up, req down, ack down
   logic                   slip_req;
   logic                   slip_ack;

   // bitslip side
   modport slipper (
      output aligned,
      output aligned_valid,
      output slip_ack,
      input  slip_req
   );

   // aligner side
   modport aligner (
      input  aligned,
      input  aligned_valid,
      input  slip_ack,
      output slip_req
   );

endinterface

`default_nettype wire

// File: sp3_demux.sv
/* word-pair capture and even/odd bit separation into lane a and lane b,
   one raw_valid strobe per pair */

`timescale 1ns/10ps
`default_nettype none

`include "sp3_rx_defs.svh"

module sp3_demux (
   input  logic                   mgtclk,
   input  logic                   reset,
   input  logic [`SP3_WORD_W-1:0] mgtword,
   output logic [`SP3_WORD_W-1:0] raw_a,
   output logic [`SP3_WORD_W-1:0] raw_b,
   output logic                   raw_valid
);

   // each lane gets half its bits from each word of a pair
   localparam int HALF = `SP3_WORD_W / 2;

   // 0 = first word of a pair, 1 = second word
   logic                   phase;

   // first word of the current pair
   logic [`SP3_WORD_W-1:0] first_word;

   // separated lane words, first word in the low half
   logic [`SP3_WORD_W-1:0] sep_a;
   logic [`SP3_WORD_W-1:0] sep_b;

   //////////////////////
   // pair phase
   //////////////////////

   always_ff @(posedge mgtclk or posedge reset) begin
      if (reset) begin
         phase     <= 1'b0;
         raw_valid <= 1'b0;
      end else begin
         phase     <= ~phase;
         // strobe in the cycle after the second word is sampled
         raw_valid <= phase;
      end
   end

   // hold the first word until its partner shows up
   always_ff @(posedge mgtclk) begin
      if (!phase) begin
         first_word <= mgtword;
      end
   end

   //////////////////////
   // bit separation
   //////////////////////

   // even bits to lane a, odd bits to lane b
   // second word is taken straight off the bus on its phase-1 edge
   for (genvar i = 0; i < HALF; i++) begin : g_sep
      assign sep_a[i]        = first_word[2*i];
      assign sep_a[HALF + i] = mgtword[2*i];
      assign sep_b[i]        = first_word[2*i + 1];
      assign sep_b[HALF + i] = mgtword[2*i + 1];
   end

   // lane words update once per pair and hold between strobes
   always_ff @(posedge mgtclk) begin
      if (phase) begin
         raw_a <= sep_a;
         raw_b <= sep_b;
      end
   end

endmodule

`default_nettype wire

// File: sp3_bitslip.sv
/* per-lane slip offset with four-phase req/ack responder and
   64-to-32 window select over the lane word history */

`timescale 1ns/10ps
`default_nettype none

`include "sp3_rx_defs.svh"

module sp3_bitslip (
   input  logic                   mgtclk,
   input  logic                   reset,
   input  logic [`SP3_WORD_W-1:0] raw,
   input  logic                   raw_valid,
   sp3_lane_if.slipper            lane,
   output logic [`SP3_SLIP_W-1:0] slip
);

   localparam int CAT_W = 2 * `SP3_WORD_W;

   // previous lane word
   logic [`SP3_WORD_W-1:0] hist;

   // previous word on top, current below
   logic [CAT_W-1:0]       cat;

   // selected 32-bit window
   logic [`SP3_WORD_W-1:0] window;

   //////////////////////
   // slip handshake
   //////////////////////

   // one increment per handshake
   // ack rises the cycle after req is seen, falls once req is gone
   always_ff @(posedge mgtclk or posedge reset) begin
      if (reset) begin
         slip          <= '0;
         lane.slip_ack <= 1'b0;
      end else begin
         if (lane.slip_req && !lane.slip_ack) begin
            // wraps 31 -> 0 on its own
            slip          <= slip + 1'b1;
            lane.slip_ack <= 1'b1;
         end else if (!lane.slip_req && lane.slip_ack) begin
            lane.slip_ack <= 1'b0;
         end
      end
   end

   //////////////////////
   // window select
   //////////////////////

   assign cat = {hist, raw};

   // offset 0 gives the previous word untouched
   // each step moves the window one bit toward the current word
   assign window = cat[(CAT_W - 1) - slip -: `SP3_WORD_W];

   // history and output load together on the lane strobe
   // the offset in use is the one present at that edge
   always_ff @(posedge mgtclk or posedge reset) begin
      if (reset) begin
         hist               <= '0;
         lane.aligned       <= '0;
         lane.aligned_valid <= 1'b0;
      end else begin
         lane.aligned_valid <= raw_valid;
         if (raw_valid) begin
            hist         <= raw;
            lane.aligned <= window;
         end
      end
   end

endmodule

`default_nettype wire

// File: sp3_frame_aligner.sv
/* per-lane header check, search/lock FSM and slip requester */

`timescale 1ns/10ps
`default_nettype none

`include "sp3_rx_defs.svh"

module sp3_frame_aligner (
   input  logic        mgtclk,
   input  logic        reset,
   sp3_lane_if.aligner lane,
   output logic        locked
);

   // one run counter serves good, bad and settle counts
   localparam int CNT_W = $clog2(`SP3_LOCK_COUNT + 1);

   localparam logic [CNT_W-1:0] LOCK_LAST   = CNT_W'(`SP3_LOCK_COUNT - 1);
   localparam logic [CNT_W-1:0] UNLOCK_LAST = CNT_W'(`SP3_UNLOCK_COUNT - 1);
   localparam logic [CNT_W-1:0] SETTLE_LAST = CNT_W'(`SP3_SETTLE_WORDS - 1);

   sp3_rx_pkg::align_state_t state;

   logic [CNT_W-1:0] run_cnt;

   // header nibble of the current aligned word
   logic [3:0]       hdr;
   logic             hdr_good;

   //////////////////////
   // header check
   //////////////////////

   assign hdr      = lane.aligned[`SP3_WORD_W-1 -: 4];
   assign hdr_good = (hdr == `SP3_HDR_A) || (hdr == `SP3_HDR_B);

   // request is held for the whole SLIP_REQ state
   assign lane.slip_req = (state == sp3_rx_pkg::SLIP_REQ);

   //////////////////////
   // search / lock FSM
   //////////////////////

   always_ff @(posedge mgtclk or posedge reset) begin
      if (reset) begin
         // first words after reset straddle the cleared history
         state   <= sp3_rx_pkg::SETTLE;
         run_cnt <= '0;
         locked  <= 1'b0;
      end else begin
         case (state)
            sp3_rx_pkg::SEARCH: begin
               if (lane.aligned_valid) begin
                  if (hdr_good) begin
                     if (run_cnt == LOCK_LAST) begin
                        state   <= sp3_rx_pkg::LOCKED;
                        run_cnt <= '0;
                        locked  <= 1'b1;
                     end else begin
                        run_cnt <= run_cnt + 1'b1;
                     end
                  end else begin
                     // any bad header restarts the count and slips
                     run_cnt <= '0;
                     state   <= sp3_rx_pkg::SLIP_REQ;
                  end
               end
            end

            sp3_rx_pkg::SLIP_REQ: begin
               // drop req as soon as the slipper acks
               if (lane.slip_ack) begin
                  state <= sp3_rx_pkg::SLIP_WAIT;
               end
            end

            sp3_rx_pkg::SLIP_WAIT: begin
               // handshake done once ack is back low
               if (!lane.slip_ack) begin
                  state   <= sp3_rx_pkg::SETTLE;
                  run_cnt <= '0;
               end
            end

            sp3_rx_pkg::SETTLE: begin
               // words here may still straddle the old window
               if (lane.aligned_valid) begin
                  if (run_cnt == SETTLE_LAST) begin
                     state   <= sp3_rx_pkg::SEARCH;
                     run_cnt <= '0;
                  end else begin
                     run_cnt <= run_cnt + 1'b1;
                  end
               end
            end

            sp3_rx_pkg::LOCKED: begin
               if (lane.aligned_valid) begin
                  if (hdr_good) begin
                     run_cnt <= '0;
                  end else if (run_cnt == UNLOCK_LAST) begin
                     state   <= sp3_rx_pkg::SEARCH;
                     run_cnt <= '0;
                     locked  <= 1'b0;
                  end else begin
                     run_cnt <= run_cnt + 1'b1;
                  end
               end
            end

            default: begin
               state   <= sp3_rx_pkg::SEARCH;
               run_cnt <= '0;
               locked  <= 1'b0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: sp3_rx_top.sv
/* SPROCKET3 uplink receive front end: demux plus two bitslip and
   frame aligner lane chains */

`timescale 1ns/10ps
`default_nettype none

`include "sp3_rx_defs.svh"

module sp3_rx_top (
   input  logic                   mgtclk,
   input  logic                   reset,
   input  logic [`SP3_WORD_W-1:0] mgtword,
   output logic [`SP3_WORD_W-1:0] word_a,
   output logic [`SP3_WORD_W-1:0] word_b,
   output logic                   word_valid,
   output logic                   locked_a,
   output logic                   locked_b,
   output logic [`SP3_SLIP_W-1:0] slip_a,
   output logic [`SP3_SLIP_W-1:0] slip_b
);

   // separated lane words from the demux
   logic [`SP3_WORD_W-1:0] raw_a;
   logic [`SP3_WORD_W-1:0] raw_b;
   logic                   raw_valid;

   sp3_lane_if lane_a_if ();
   sp3_lane_if lane_b_if ();

   //////////////////////
   // demux
   //////////////////////

   sp3_demux u_demux (
      .mgtclk    (mgtclk),
      .reset     (reset),
      .mgtword   (mgtword),
      .raw_a     (raw_a),
      .raw_b     (raw_b),
      .raw_valid (raw_valid)
   );

   //////////////////////
   // lane a
   //////////////////////

   sp3_bitslip u_slip_a (
      .mgtclk    (mgtclk),
      .reset     (reset),
      .raw       (raw_a),
      .raw_valid (raw_valid),
      .lane      (lane_a_if.slipper),
      .slip      (slip_a)
   );

   sp3_frame_aligner u_align_a (
      .mgtclk (mgtclk),
      .reset  (reset),
      .lane   (lane_a_if.aligner),
      .locked (locked_a)
   );

   //////////////////////
   // lane b
   //////////////////////

   sp3_bitslip u_slip_b (
      .mgtclk    (mgtclk),
      .reset     (reset),
      .raw       (raw_b),
      .raw_valid (raw_valid),
      .lane      (lane_b_if.slipper),
      .slip      (slip_b)
   );

   sp3_frame_aligner u_align_b (
      .mgtclk (mgtclk),
      .reset  (reset),
      .lane   (lane_b_if.aligner),
      .locked (locked_b)
   );

   // both lanes share one strobe, lane a's stands for both
   assign word_valid = lane_a_if.aligned_valid;
   assign word_a     = lane_a_if.aligned;
   assign word_b     = lane_b_if.aligned;

endmodule

`default_nettype wire

// File: sp3_rx_assertions.sv
/* concurrent checks on the slip handshake, the lane strobe and the
   lock flag, bound into the frame aligner */

`timescale 1ns/10ps
`default_nettype none

module sp3_rx_assertions (
   input logic mgtclk,
   input logic reset,
   input logic slip_req,
   input logic slip_ack,
   input logic aligned_valid,
   input logic locked,
   input logic locked_state
);

   //////////////////////
   // handshake
   //////////////////////

   // ack only answers a live request
   ack_rise: assert property (@(posedge mgtclk) disable iff (reset)
      $rose(slip_ack) |-> $past(slip_req))
      else $error("slip_ack rose without slip_req");

   // ack holds until the request is gone
   ack_fall: assert property (@(posedge mgtclk) disable iff (reset)
      $fell(slip_ack) |-> !$past(slip_req))
      else $error("slip_ack fell while slip_req was high");

   //////////////////////
   // strobe and lock
   //////////////////////

   // one lane word every second cycle
   strobe_gap: assert property (@(posedge mgtclk) disable iff (reset)
      aligned_valid |=> !aligned_valid)
      else $error("aligned_valid high two cycles in a row");

   lock_state: assert property (@(posedge mgtclk) disable iff (reset)
      locked |-> locked_state)
      else $error("locked high outside the LOCKED state");

endmodule

// the aligner sees the whole lane link plus its own lock flag
bind sp3_frame_aligner sp3_rx_assertions u_align_chk (
   .mgtclk        (mgtclk),
   .reset         (reset),
   .slip_req      (lane.slip_req),
   .slip_ack      (lane.slip_ack),
   .aligned_valid (lane.aligned_valid),
   .locked        (locked),
   .locked_state  (state == sp3_rx_pkg::LOCKED)
);

`default_nettype wire

// File: sp3_rx_tb.sv
/* testbench for the SPROCKET3 receive front end: clock, reset, xorshift
   lane stream model, output checks, tests, watchdog and final counts */

`timescale 1ns/10ps
`default_nettype none

`include "sp3_rx_defs.svh"

module sp3_rx_tb;

   localparam int PERIOD     = 40;
   // worst case search: a full wrap of 32 slips, each slip costs
   // one bad strobe, the handshake and the settle strobes
   localparam int SEARCH_CYC = 32 * 12 + 4 * `SP3_LOCK_COUNT;
   localparam int DATA_PAIRS = 64;
   localparam int TEST_CYC   = 8 + SEARCH_CYC + 2 * DATA_PAIRS;
   localparam int RUN_CYC    = 4 * TEST_CYC + 8 + 4 * `SP3_UNLOCK_COUNT;
   localparam int LIMIT      = RUN_CYC * 3 / 2;

   logic                   mgtclk;
   logic                   reset;
   logic [`SP3_WORD_W-1:0] mgtword;
   logic [`SP3_WORD_W-1:0] word_a;
   logic [`SP3_WORD_W-1:0] word_b;
   logic                   word_valid;
   logic                   locked_a;
   logic                   locked_b;
   logic [`SP3_SLIP_W-1:0] slip_a;
   logic [`SP3_SLIP_W-1:0] slip_b;

   // model state
   logic [31:0]            rng;
   logic [31:0]            lw_a [0:4095];
   logic [31:0]            lw_b [0:4095];
   logic [31:0]            frm_a;
   logic [31:0]            frm_b;
   logic [4:0]             off_a;
   logic [4:0]             off_b;
   int                     bad_left_b;
   bit                     tb_phase;
   int                     pair_cnt;
   int                     strobe_cnt;
   bit                     hold_a;
   bit                     hold_a_seen;
   // both lanes start aligned, so every strobe is checked
   bit                     aligned_start;

   int                     errors;
   int                     cycles;
   int                     tests_run;
   int                     tests_failed;
   int                     err_start;

   sp3_rx_top DUT (
      .mgtclk     (mgtclk),
      .reset      (reset),
      .mgtword    (mgtword),
      .word_a     (word_a),
      .word_b     (word_b),
      .word_valid (word_valid),
      .locked_a   (locked_a),
      .locked_b   (locked_b),
      .slip_a     (slip_a),
      .slip_b     (slip_b)
   );

   ////////////////////
   // helpers
   ////////////////////

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // window rule: bits 63-s down to 32-s of {previous, current}
   function automatic logic [31:0] window_sel(input logic [31:0] prev,
                                              input logic [31:0] cur,
                                              input logic [4:0]  s);
      logic [63:0] cat;
      cat = {prev, cur} << s;
      return cat[63:32];
   endfunction

   task automatic compare(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
      if (got !== exp) begin
         $display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // every output at its cleared value
   task automatic check_cleared();
      compare("word_valid", 32'(word_valid), 32'd0);
      compare("locked_a", 32'(locked_a), 32'd0);
      compare("locked_b", 32'(locked_b), 32'd0);
      compare("slip_a", 32'(slip_a), 32'd0);
      compare("slip_b", 32'(slip_b), 32'd0);
      compare("word_a", word_a, 32'd0);
      compare("word_b", word_b, 32'd0);
   endtask

   // random frame, header picked at random unless corrupted
   task automatic make_frame(input bit bad, output logic [31:0] f);
      logic [3:0] hdr;
      rng = xorshift(rng);
      hdr = rng[31] ? `SP3_HDR_A : `SP3_HDR_B;
      f   = {bad ? 4'b0000 : hdr, rng[27:0]};
   endtask

   task automatic apply_reset(input bit check);
      @(posedge mgtclk);
      #1;
      reset = 1'b1;
      repeat (8) begin
         @(negedge mgtclk);
         if (check) begin
            check_cleared();
         end
      end
      @(posedge mgtclk);
      #1;
      reset = 1'b0;
      // first cycle out of reset, nothing through the pipe yet
      @(negedge mgtclk);
      if (check) begin
         check_cleared();
      end
   endtask

   task automatic wait_lock();
      int n;
      n = 0;
      while (!(locked_a && locked_b) && n < 2 * SEARCH_CYC) begin
         @(negedge mgtclk);
         n++;
      end
      if (!(locked_a && locked_b)) begin
         $display("lanes did not both lock within %0d cycles", 2 * SEARCH_CYC);
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == err_start) begin
         $display("test %s: passed", name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, errors - err_start);
      end
      err_start = errors;
   endtask

   ////////////////////
   // clock and watchdog
   ////////////////////

   initial begin
      mgtclk = 1'b0;
      forever #(PERIOD / 2) mgtclk = ~mgtclk;
   end

   always @(posedge mgtclk) begin
      cycles++;
      if (cycles >= LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", LIMIT);
         $display("** FAIL **");
         $finish;
      end
   end

   ////////////////////
   // lane stream driver
   ////////////////////

   // each lane is a frame stream delayed by off bits, cut into 32-bit
   // lane words and interleaved two words per pair, even bits lane a
   initial begin
      logic [31:0] nf_a;
      logic [31:0] nf_b;
      logic [63:0] two;
      logic [31:0] w1;
      forever begin
         @(posedge mgtclk);
         #2;
         if (reset) begin
            tb_phase = 1'b0;
            pair_cnt = 0;
            frm_a    = '0;
            frm_b    = '0;
            mgtword  = '0;
         end else if (!tb_phase) begin
            make_frame(1'b0, nf_a);
            make_frame(bad_left_b > 0, nf_b);
            if (bad_left_b > 0) begin
               bad_left_b--;
            end
            two = {frm_a, nf_a} >> off_a;
            lw_a[pair_cnt % 4096] = two[31:0];
            two = {frm_b, nf_b} >> off_b;
            lw_b[pair_cnt % 4096] = two[31:0];
            frm_a = nf_a;
            frm_b = nf_b;
            for (int i = 0; i < 16; i++) begin
               mgtword[2*i]     = lw_a[pair_cnt % 4096][i];
               mgtword[2*i + 1] = lw_b[pair_cnt % 4096][i];
            end
            tb_phase = 1'b1;
         end else begin
            // second word carries the upper halves
            for (int i = 0; i < 16; i++) begin
               w1[2*i]     = lw_a[pair_cnt % 4096][16 + i];
               w1[2*i + 1] = lw_b[pair_cnt % 4096][16 + i];
            end
            mgtword  = w1;
            tb_phase = 1'b0;
            pair_cnt++;
         end
      end
   end

   ////////////////////
   // output monitor
   ////////////////////

   // strobe n carries lane words n-1 and n through the window
   always @(negedge mgtclk) begin
      if (reset) begin
         strobe_cnt = 0;
      end else begin
         if (hold_a && !locked_a && !hold_a_seen) begin
            $display("locked_a dropped at t=%0t while lane a was steady", $time);
            hold_a_seen = 1'b1;
            errors++;
         end
         if (word_valid) begin
            if ((locked_a || aligned_start) && strobe_cnt > 0) begin
               compare("slip_a", 32'(slip_a), 32'(off_a));
               compare("word_a", word_a, window_sel(lw_a[(strobe_cnt - 1) % 4096],
                       lw_a[strobe_cnt % 4096], off_a));
            end
            if ((locked_b || aligned_start) && strobe_cnt > 0) begin
               compare("slip_b", 32'(slip_b), 32'(off_b));
               compare("word_b", word_b, window_sel(lw_b[(strobe_cnt - 1) % 4096],
                       lw_b[strobe_cnt % 4096], off_b));
            end
            strobe_cnt++;
         end
      end
   end

   ////////////////////
   // tests
   ////////////////////

   initial begin
      int n;
      reset         = 1'b1;
      mgtword       = '0;
      rng           = 32'h18abe75d;
      off_a         = '0;
      off_b         = '0;
      bad_left_b    = 0;
      hold_a        = 1'b0;
      hold_a_seen   = 1'b0;
      aligned_start = 1'b0;
      errors        = 0;
      cycles        = 0;
      tests_run     = 0;
      tests_failed  = 0;
      err_start     = 0;

      apply_reset(1'b1);
      end_test("reset");

      // both lanes frame-aligned, slips never leave zero
      aligned_start = 1'b1;
      apply_reset(1'b0);
      wait_lock();
      compare("slip_a", 32'(slip_a), 32'd0);
      compare("slip_b", 32'(slip_b), 32'd0);
      repeat (2 * DATA_PAIRS) @(negedge mgtclk);
      aligned_start = 1'b0;
      end_test("separation at offset zero");

      rng   = xorshift(rng);
      off_a = rng[4:0];
      off_b = rng[12:8];
      apply_reset(1'b0);
      wait_lock();
      repeat (2 * DATA_PAIRS) @(negedge mgtclk);
      end_test("alignment search");

      // lane a aligned, lane b at a nonzero offset
      rng   = xorshift(rng);
      off_a = '0;
      off_b = 5'(1 + rng[7:0] % 31);
      apply_reset(1'b0);
      wait_lock();
      hold_a = 1'b1;
      repeat (2 * DATA_PAIRS) @(negedge mgtclk);
      end_test("lane independence");

      // break lane b framing, then resume at a different offset
      bad_left_b = `SP3_UNLOCK_COUNT;
      n = 0;
      while (locked_b && n < 8 * `SP3_UNLOCK_COUNT) begin
         @(negedge mgtclk);
         n++;
      end
      if (locked_b) begin
         $display("locked_b stayed high after corrupted headers");
         errors++;
      end
      rng   = xorshift(rng);
      off_b = off_b + 5'(1 + rng[7:0] % 31);
      wait_lock();
      repeat (2 * DATA_PAIRS) @(negedge mgtclk);
      hold_a = 1'b0;
      end_test("loss and recovery");

      $display("tests %0d, passed %0d, failed %0d, errors %0d",
               tests_run, tests_run - tests_failed, tests_failed, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
sp3_rx_pkg.sv
sp3_lane_if.sv
sp3_demux.sv
sp3_bitslip.sv
sp3_frame_aligner.sv
sp3_rx_top.sv
sp3_rx_assertions.sv
sp3_rx_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the receive front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module sp3_rx_tb -o sp3_rx_sim \
   && ./obj_dir/sp3_rx_sim > sim.log 2>&1

cat sim.log

grep -qx '\*\* PASS \*\*' sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
